// File: filelist.f
+incdir+rtl
rtl/mojo_pkg.sv
rtl/vga_timing.sv
rtl/color_bar_gen.sv
rtl/sdram_init_seq.sv
rtl/mojo_main.sv
rtl/mojo_top.sv
test/tb_mojo_top.sv

// File: rtl/color_bar_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "mojo_consts.svh"

module color_bar_gen import mojo_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           pix_en,
  input  wire vga_pos_t pos,
  output rgb_t          pixel,
  output vga_pos_t      pos_out
);

  logic [2:0] bar_idx;

  // the last boundary that x has passed gives the bar number.
  always_comb begin
    bar_idx = 3'd0;
    for (int i = 1; i < 8; i++) begin
      if (pos.x >= i * `BAR_WIDTH) begin
        bar_idx = 3'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pixel <= '{r: 1'b0, g: 1'b0, b: 1'b0};
    end else if (pix_en) begin
      if (pos.active) begin
        pixel.r <= bar_idx[2];
        pixel.g <= bar_idx[1];
        pixel.b <= bar_idx[0];
      end else begin
        pixel <= '{r: 1'b0, g: 1'b0, b: 1'b0}; // blank in the porches and sync.
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos_out <= '{x: 10'd0, y: 10'd0, active: 1'b0, hs: 1'b1, vs: 1'b1};
    end else if (pix_en) begin
      pos_out <= pos; // keeps sync aligned with the pixel.
    end
  end

endmodule

`default_nettype wire

// File: rtl/mojo_consts.svh
`ifndef MOJO_CONSTS_SVH
`define MOJO_CONSTS_SVH

// 640x480 at 60 Hz, counted in pixels of the 25 MHz pixel clock.
`define H_ACTIVE 10'd640
`define H_FRONT  10'd16
`define H_SYNC   10'd96
`define H_BACK   10'd48

// vertical timing in lines.
`define V_ACTIVE 10'd480
`define V_FRONT  10'd10
`define V_SYNC   10'd2
`define V_BACK   10'd33

`define BAR_WIDTH 10'd80

// SDRAM power-up and recovery times in 50 MHz clocks.
`define SDRAM_INIT_WAIT 13'd5000
`define SDRAM_TRP       13'd3
`define SDRAM_TRFC      13'd8
`define SDRAM_TMRD      13'd2

`define SDRAM_REFRESH_INTERVAL 9'd390

// burst length 1, sequential burst and CAS latency 2.
`define SDRAM_MODE 13'b000_0_00_010_0_000

`endif

// File: rtl/mojo_main.sv
`timescale 1ns/1ps
`default_nettype none

module mojo_main import mojo_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  output logic [7:0] led,
  output sdram_bus_t sdram,
  output logic       vga_hs,
  output logic       vga_vs,
  output logic       vga_r,
  output logic       vga_g,
  output logic       vga_b
);

  logic       pix_en;
  vga_pos_t   pos;
  vga_pos_t   pos_out;
  rgb_t       pixel;
  logic       init_done;
  logic       vs_d;
  logic [6:0] frame_cnt;

  vga_timing timing (
    .clk    (clk),
    .rst_n  (rst_n),
    .pix_en (pix_en),
    .pos    (pos)
  );

  color_bar_gen bars (
    .clk     (clk),
    .rst_n   (rst_n),
    .pix_en  (pix_en),
    .pos     (pos),
    .pixel   (pixel),
    .pos_out (pos_out)
  );

  sdram_init_seq sdram_init (
    .clk       (clk),
    .rst_n     (rst_n),
    .bus       (sdram),
    .init_done (init_done)
  );

  // color and sync leave through the same register stage.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vga_hs <= 1'b1;
      vga_vs <= 1'b1;
      vga_r  <= 1'b0;
      vga_g  <= 1'b0;
      vga_b  <= 1'b0;
    end else begin
      vga_hs <= pos_out.hs;
      vga_vs <= pos_out.vs;
      vga_r  <= pixel.r;
      vga_g  <= pixel.g;
      vga_b  <= pixel.b;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vs_d      <= 1'b1;
      frame_cnt <= '0;
      led       <= '0;
    end else begin
      vs_d <= vga_vs;
      if (vs_d && !vga_vs) begin
        frame_cnt <= frame_cnt + 7'd1; // counts falling edges of vs on the pin.
      end
      led <= {init_done, frame_cnt};
    end
  end

endmodule

`default_nettype wire

// File: rtl/mojo_pkg.sv
`default_nettype none

package mojo_pkg;

  // SDRAM commands as the {ras, cas, we} pattern.
  typedef enum logic [2:0] {
    LOAD_MODE = 3'b000,
    REFRESH   = 3'b001,
    PRECHARGE = 3'b010,
    NOP       = 3'b111
  } sdram_cmd_t;

  typedef struct packed {
    logic        cs;
    logic        ras;
    logic        cas;
    logic        we;
    logic        cle;
    logic        dqm;
    logic [1:0]  ba;
    logic [12:0] a;
  } sdram_bus_t;

  // raw counter position with decoded sync and blanking.
  typedef struct packed {
    logic [9:0] x;
    logic [9:0] y;
    logic       active;
    logic       hs;
    logic       vs;
  } vga_pos_t;

  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_t;

endpackage

`default_nettype wire

// File: rtl/mojo_top.sv
`timescale 1ns/1ps
`default_nettype none

module mojo_top import mojo_pkg::*; (
  input  wire         clk,
  input  wire         rst_n,
  input  wire         cclk,
  output logic [7:0]  led,
  output logic        spi_miso,
  input  wire         spi_ss,
  input  wire         spi_mosi,
  input  wire         spi_sck,
  output logic [3:0]  spi_channel,
  input  wire         avr_tx,
  output logic        avr_rx,
  input  wire         avr_rx_busy,
  output logic        sdram_clk,
  output logic        sdram_cle,
  output logic        sdram_dqm,
  output logic        sdram_cs,
  output logic        sdram_we,
  output logic        sdram_cas,
  output logic        sdram_ras,
  output logic [1:0]  sdram_ba,
  output logic [12:0] sdram_a,
  inout  wire  [7:0]  sdram_dq,
  output logic        vga_hs,
  output logic        vga_vs,
  output logic        vga_r,
  output logic        vga_g,
  output logic        vga_b
);

  sdram_bus_t sdram;

  mojo_main core (
    .clk    (clk),
    .rst_n  (rst_n),
    .led    (led),
    .sdram  (sdram),
    .vga_hs (vga_hs),
    .vga_vs (vga_vs),
    .vga_r  (vga_r),
    .vga_g  (vga_g),
    .vga_b  (vga_b)
  );

  // inverted clock puts the SDRAM sampling edge mid-cycle.
  assign sdram_clk = ~clk;

  assign sdram_cle = sdram.cle;
  assign sdram_dqm = sdram.dqm;
  assign sdram_cs  = sdram.cs;
  assign sdram_we  = sdram.we;
  assign sdram_cas = sdram.cas;
  assign sdram_ras = sdram.ras;
  assign sdram_ba  = sdram.ba;
  assign sdram_a   = sdram.a;

  assign sdram_dq = 8'bzzzz_zzzz; // no data transfers yet.

  // the AVR link is idle.
  assign spi_miso    = 1'b0;
  assign avr_rx      = 1'b1;
  assign spi_channel = 4'hf;

endmodule

`default_nettype wire

// File: rtl/sdram_init_seq.sv
`timescale 1ns/1ps
`default_nettype none
`include "mojo_consts.svh"

module sdram_init_seq import mojo_pkg::*; (
  input  wire        clk,
  input  wire        rst_n,
  output sdram_bus_t bus,
  output logic       init_done
);

  typedef enum logic [2:0] {
    S_WAIT,
    S_PRECHARGE,
    S_REFRESH1,
    S_REFRESH2,
    S_LOAD_MODE,
    S_RUN
  } state_t;

  state_t      state;
  logic [12:0] delay;
  logic [8:0]  interval;

  function automatic sdram_bus_t cmd_word(input sdram_cmd_t cmd, input logic [12:0] addr);
    sdram_bus_t w;
    w.cs  = (cmd == NOP);
    {w.ras, w.cas, w.we} = cmd;
    w.cle = 1'b1;
    w.dqm = 1'b1;
    w.ba  = 2'b00;
    w.a   = addr;
    return w;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_WAIT;
      delay     <= `SDRAM_INIT_WAIT - 13'd1;
      interval  <= '0;
      init_done <= 1'b0;
      bus       <= '{cs: 1'b1, ras: 1'b1, cas: 1'b1, we: 1'b1, cle: 1'b0,
                     dqm: 1'b1, ba: 2'b00, a: 13'd0};
    end else begin
      if (state != S_WAIT) begin
        bus <= cmd_word(NOP, 13'd0); // one clock per command.
      end
      case (state)
        S_WAIT: begin
          if (delay == 13'd0) begin
            bus   <= cmd_word(PRECHARGE, 13'h0400); // a[10] selects all banks.
            delay <= `SDRAM_TRP;
            state <= S_PRECHARGE;
          end else begin
            delay <= delay - 13'd1;
          end
        end
        S_PRECHARGE: begin
          if (delay == 13'd0) begin
            bus   <= cmd_word(REFRESH, 13'd0);
            delay <= `SDRAM_TRFC;
            state <= S_REFRESH1;
          end else begin
            delay <= delay - 13'd1;
          end
        end
        S_REFRESH1: begin
          if (delay == 13'd0) begin
            bus   <= cmd_word(REFRESH, 13'd0);
            delay <= `SDRAM_TRFC;
            state <= S_REFRESH2;
          end else begin
            delay <= delay - 13'd1;
          end
        end
        S_REFRESH2: begin
          if (delay == 13'd0) begin
            bus   <= cmd_word(LOAD_MODE, `SDRAM_MODE);
            delay <= `SDRAM_TMRD;
            state <= S_LOAD_MODE;
          end else begin
            delay <= delay - 13'd1;
          end
        end
        S_LOAD_MODE: begin
          if (delay == 13'd0) begin
            init_done <= 1'b1;
            interval  <= `SDRAM_REFRESH_INTERVAL - 9'd1;
            state     <= S_RUN;
          end else begin
            delay <= delay - 13'd1;
          end
        end
        S_RUN: begin
          if (interval == 9'd0) begin
            bus      <= cmd_word(REFRESH, 13'd0);
            interval <= `SDRAM_REFRESH_INTERVAL - 9'd1; // spacing is command to command.
          end else begin
            interval <= interval - 9'd1;
          end
        end
        default: state <= S_WAIT;
      endcase
    end
  end

  a_nop_during_wait: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state == S_WAIT) |-> (bus.cs && !bus.cle)
  );

  a_no_mode_after_init: assert property (
    @(posedge clk) disable iff (!rst_n)
    init_done |-> (bus.cs || ({bus.ras, bus.cas, bus.we} != LOAD_MODE))
  );

endmodule

`default_nettype wire

// File: rtl/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "mojo_consts.svh"

module vga_timing import mojo_pkg::*; (
  input  wire      clk,
  input  wire      rst_n,
  output logic     pix_en,
  output vga_pos_t pos
);

  localparam logic [9:0] H_SYNC_START = `H_ACTIVE + `H_FRONT;
  localparam logic [9:0] H_SYNC_END   = H_SYNC_START + `H_SYNC;
  localparam logic [9:0] H_TOTAL      = H_SYNC_END + `H_BACK;
  localparam logic [9:0] V_SYNC_START = `V_ACTIVE + `V_FRONT;
  localparam logic [9:0] V_SYNC_END   = V_SYNC_START + `V_SYNC;
  localparam logic [9:0] V_TOTAL      = V_SYNC_END + `V_BACK;

  logic [9:0] h_cnt;
  logic [9:0] v_cnt;
  logic       h_last;
  logic       v_last;

  assign h_last = (h_cnt == H_TOTAL - 10'd1);
  assign v_last = (v_cnt == V_TOTAL - 10'd1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_en <= 1'b0;
    end else begin
      pix_en <= ~pix_en; // 25 MHz pixel rate from the 50 MHz clock.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (pix_en) begin
      if (h_last) begin
        h_cnt <= '0;
        v_cnt <= v_last ? 10'd0 : v_cnt + 10'd1; // lines advance at the end of each line.
      end else begin
        h_cnt <= h_cnt + 10'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pos <= '{x: 10'd0, y: 10'd0, active: 1'b0, hs: 1'b1, vs: 1'b1};
    end else if (pix_en) begin
      pos.x      <= h_cnt;
      pos.y      <= v_cnt;
      pos.active <= (h_cnt < `H_ACTIVE) && (v_cnt < `V_ACTIVE);
      pos.hs     <= !((h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END)); // sync is active low.
      pos.vs     <= !((v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END));
    end
  end

  // the counter runs one pixel ahead of the registered hs, so its window moves by one.
  a_hs_in_window: assert property (
    @(posedge clk) disable iff (!rst_n)
    !pos.hs |-> ((h_cnt > H_SYNC_START) && (h_cnt <= H_SYNC_END))
  );

  a_pix_en_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    pix_en |=> !pix_en
  );

endmodule

`default_nettype wire

// File: test/tb_mojo_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "mojo_consts.svh"

module tb_mojo_top;

  localparam int H_TOTAL    = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
  localparam int V_TOTAL    = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
  localparam int LINE_CLKS  = 2 * H_TOTAL;
  localparam int FRAME_CLKS = V_TOTAL * LINE_CLKS;
  localparam int REF_INT    = `SDRAM_REFRESH_INTERVAL;

  // standard SDRAM {ras, cas, we} codes.
  localparam logic [2:0] CMD_PRECHARGE = 3'b010;
  localparam logic [2:0] CMD_REFRESH   = 3'b001;
  localparam logic [2:0] CMD_LOAD_MODE = 3'b000;

  logic        clk;
  logic        rst_n;
  logic        cclk;
  logic        spi_ss;
  logic        spi_mosi;
  logic        spi_sck;
  logic        avr_tx;
  logic        avr_rx_busy;
  logic [31:0] rnd;
  wire  [7:0]  led;
  wire         spi_miso;
  wire  [3:0]  spi_channel;
  wire         avr_rx;
  wire         sdram_clk;
  wire         sdram_cle;
  wire         sdram_dqm;
  wire         sdram_cs;
  wire         sdram_we;
  wire         sdram_cas;
  wire         sdram_ras;
  wire  [1:0]  sdram_ba;
  wire  [12:0] sdram_a;
  wire  [7:0]  sdram_dq;
  wire         vga_hs;
  wire         vga_vs;
  wire         vga_r;
  wire         vga_g;
  wire         vga_b;

  int cycle = 0;
  int release_cyc = 0;
  int checks = 0;
  int errors = 0;

  mojo_top UUT (
    .clk(clk), .rst_n(rst_n), .cclk(cclk), .led(led),
    .spi_miso(spi_miso), .spi_ss(spi_ss), .spi_mosi(spi_mosi), .spi_sck(spi_sck),
    .spi_channel(spi_channel), .avr_tx(avr_tx), .avr_rx(avr_rx),
    .avr_rx_busy(avr_rx_busy), .sdram_clk(sdram_clk), .sdram_cle(sdram_cle),
    .sdram_dqm(sdram_dqm), .sdram_cs(sdram_cs), .sdram_we(sdram_we),
    .sdram_cas(sdram_cas), .sdram_ras(sdram_ras), .sdram_ba(sdram_ba),
    .sdram_a(sdram_a), .sdram_dq(sdram_dq), .vga_hs(vga_hs), .vga_vs(vga_vs),
    .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1; // outputs are sampled on the falling edge, where this is stable.
  end

  // the unused SPI and AVR inputs wander at random.
  always @(posedge clk) begin
    #1;
    rnd = $urandom;
    {spi_ss, spi_mosi, spi_sck, avr_tx, avr_rx_busy} = rnd[4:0];
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  // sel 0 watches hs and sel 1 watches vs. returns the cycle of the first matching sample.
  task automatic wait_sync(input int sel, input logic level, input int limit,
                           output int when);
    int n;
    n = 0;
    when = -1;
    while (when < 0 && n < limit) begin
      @(negedge clk);
      n++;
      if (((sel == 0) ? vga_hs : vga_vs) === level) begin
        when = cycle;
      end
    end
    if (when < 0) begin
      errors++;
      $display("timeout while waiting for %s to go %b", (sel == 0) ? "hs" : "vs", level);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    release_cyc = cycle;
    check("reset_cs", 1'b1, sdram_cs);
    check("reset_cmd", 3'b111, {sdram_ras, sdram_cas, sdram_we});
    check("reset_cle", 1'b0, sdram_cle);
    check("reset_dqm", 1'b1, sdram_dqm);
    check("reset_sync", 2'b11, {vga_hs, vga_vs});
    check("reset_rgb", 3'b000, {vga_r, vga_g, vga_b});
    check("reset_led", 8'h00, led);
    check("reset_dq", 8'bzzzz_zzzz, sdram_dq);
    repeat (8) begin
      @(negedge clk);
      check("idle_spi_miso", 1'b0, spi_miso);
      check("idle_avr_rx", 1'b1, avr_rx);
      check("idle_spi_channel", 4'hf, spi_channel);
      check("idle_cs", 1'b1, sdram_cs);
      #1;
      check("sdram_clk_inv", 1'b1, sdram_clk); // the SDRAM clock is high while clk is low.
      @(posedge clk);
      #1;
      check("sdram_clk_inv", 1'b0, sdram_clk);
    end
  endtask

  task automatic test_sdram_init();
    int          cmd_cyc [4];
    logic [2:0]  cmd_code [4];
    logic [12:0] cmd_a [4];
    logic [1:0]  cmd_ba [4];
    int          n;
    int          waited;
    n = 0;
    waited = 0;
    while (n < 4 && waited < 2 * `SDRAM_INIT_WAIT) begin
      @(negedge clk);
      waited++;
      check("sdram_cle", (n > 0) || !sdram_cs, sdram_cle); // cle rises with the first command.
      if (!sdram_cs) begin
        cmd_cyc[n]  = cycle;
        cmd_code[n] = {sdram_ras, sdram_cas, sdram_we};
        cmd_a[n]    = sdram_a;
        cmd_ba[n]   = sdram_ba;
        if (n == 3) begin
          check("init_done_early", 1'b0, led[7]);
        end
        n++;
      end
    end
    if (n < 4) begin
      errors++;
      $display("timeout while waiting for the SDRAM power-up commands");
    end else begin
      check("init_wait", `SDRAM_INIT_WAIT, cmd_cyc[0] - release_cyc);
      check("cmd_precharge", CMD_PRECHARGE, cmd_code[0]);
      check("precharge_a10", 1'b1, cmd_a[0][10]);
      check("cmd_refresh1", CMD_REFRESH, cmd_code[1]);
      check("gap_trp", `SDRAM_TRP + 1, cmd_cyc[1] - cmd_cyc[0]);
      check("cmd_refresh2", CMD_REFRESH, cmd_code[2]);
      check("gap_trfc1", `SDRAM_TRFC + 1, cmd_cyc[2] - cmd_cyc[1]);
      check("cmd_load_mode", CMD_LOAD_MODE, cmd_code[3]);
      check("gap_trfc2", `SDRAM_TRFC + 1, cmd_cyc[3] - cmd_cyc[2]);
      check("mode_word", `SDRAM_MODE, cmd_a[3]);
      check("mode_ba", 2'b00, cmd_ba[3]);
      waited = 0;
      while (!led[7] && waited < 16) begin
        @(negedge clk);
        waited++;
      end
      if (!led[7]) begin
        errors++;
        $display("timeout while waiting for led[7] after the mode load");
      end
    end
  endtask

  task automatic test_refresh_interval();
    int ref_cyc [3];
    int n;
    int waited;
    n = 0;
    waited = 0;
    while (n < 3 && waited < 4 * REF_INT) begin
      @(negedge clk);
      waited++;
      if (!sdram_cs) begin
        check("periodic_cmd", CMD_REFRESH, {sdram_ras, sdram_cas, sdram_we});
        ref_cyc[n] = cycle;
        n++;
      end
    end
    if (n < 3) begin
      errors++;
      $display("timeout while waiting for periodic refresh commands");
    end else begin
      check("refresh_gap1", REF_INT, ref_cyc[1] - ref_cyc[0]);
      check("refresh_gap2", REF_INT, ref_cyc[2] - ref_cyc[1]);
    end
  endtask

  task automatic test_hsync();
    int t_fall0;
    int t_rise;
    int t_fall1;
    wait_sync(0, 1'b1, LINE_CLKS + 10, t_rise);
    wait_sync(0, 1'b0, LINE_CLKS + 10, t_fall0);
    wait_sync(0, 1'b1, LINE_CLKS + 10, t_rise);
    wait_sync(0, 1'b0, LINE_CLKS + 10, t_fall1);
    check("hs_pulse", 2 * `H_SYNC, t_rise - t_fall0);
    check("hs_period", LINE_CLKS, t_fall1 - t_fall0);
  endtask

  task automatic test_color_bars();
    int         t;
    int         bar;
    logic [2:0] exp_rgb;
    wait_sync(1, 1'b0, FRAME_CLKS + LINE_CLKS, t);
    wait_sync(1, 1'b1, 4 * LINE_CLKS, t);
    // 33 back-porch lines, then a few more, so the next line is active.
    repeat (40) begin
      wait_sync(0, 1'b0, LINE_CLKS + 10, t);
      wait_sync(0, 1'b1, LINE_CLKS + 10, t);
    end
    repeat (2 * `H_BACK) @(negedge clk);
    for (int p = 0; p < `H_ACTIVE; p++) begin
      @(negedge clk);
      bar = p / `BAR_WIDTH;
      exp_rgb = bar[2:0];
      check("color_bars", exp_rgb, {vga_r, vga_g, vga_b});
      @(negedge clk);
    end
    for (int i = 0; i < 2 * (H_TOTAL - `H_ACTIVE); i++) begin
      check("porch_blank", 3'b000, {vga_r, vga_g, vga_b});
      @(negedge clk);
    end
  endtask

  task automatic test_frames();
    int         t;
    int         f_prev;
    int         f_next;
    int         r;
    logic [6:0] cnt_prev;
    wait_sync(1, 1'b1, 4 * LINE_CLKS, t);
    wait_sync(1, 1'b0, FRAME_CLKS + LINE_CLKS, f_prev);
    repeat (4) @(negedge clk);
    cnt_prev = led[6:0];
    repeat (2) begin
      wait_sync(1, 1'b1, 4 * LINE_CLKS, r);
      check("vs_pulse", `V_SYNC * LINE_CLKS, r - f_prev);
      wait_sync(1, 1'b0, FRAME_CLKS + LINE_CLKS, f_next);
      check("vs_period", FRAME_CLKS, f_next - f_prev);
      repeat (4) @(negedge clk); // the counter lags the pin by two clocks.
      check("frame_count", 7'(cnt_prev + 7'd1), led[6:0]);
      check("led_init_done", 1'b1, led[7]);
      cnt_prev = 7'(cnt_prev + 7'd1);
      f_prev = f_next;
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    cclk = 1'b1;
    spi_ss = 1'b1;
    spi_mosi = 1'b0;
    spi_sck = 1'b0;
    avr_tx = 1'b1;
    avr_rx_busy = 1'b0;
    rnd = 32'd0;
    void'($urandom(91209));
    apply_reset();
    test_reset_state();
    test_sdram_init();
    test_refresh_interval();
    test_hsync();
    test_color_bars();
    test_frames();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
